// ==== Makefile ====
# Verilator build and run of the loopback accelerator testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_nlb_lpbk
FILELIST  ?= nlb_lpbk.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== nlb_csr.sv ====
/*
 * MMIO register block: decode, configuration registers, write lock
 * and one-cycle status readback
 */
`timescale 1ns/1ps
`include "nlb_lpbk_settings.svh"

module nlb_csr
(
  input  logic                    Clk_400,
  input  logic                    rst_n,
  input  logic                    mmio_wr_valid,
  input  logic                    mmio_rd_valid,
  input  logic [`NLB_MMIO_AW-1:0] mmio_addr,
  input  logic [`NLB_TID_W-1:0]   mmio_tid,
  input  logic [`NLB_MMIO_DW-1:0] mmio_wdata,
  input  logic                    test_done,
  input  logic [`NLB_CNT_W-1:0]   num_reads,
  input  logic [`NLB_CNT_W-1:0]   num_writes,
  input  logic [63:0]             num_clocks,
  output logic                    mmio_rsp_valid,
  output logic [`NLB_TID_W-1:0]   mmio_rsp_tid,
  output logic [`NLB_MMIO_DW-1:0] mmio_rsp_data,
  output nlb_pkg::nlb_ctl_t       ctl,
  output nlb_pkg::nlb_cfg_t       cfg,
  output logic [`NLB_ADDR_W-1:0]  src_addr,
  output logic [`NLB_ADDR_W-1:0]  dst_addr,
  output logic [`NLB_CNT_W-1:0]   num_lines
);
  import nlb_pkg::*;

  nlb_csr_word_u wdata_u;
  logic [`NLB_MMIO_DW-1:0] scratch;
  logic [`NLB_MMIO_DW-1:0] src_reg;
  logic [`NLB_MMIO_DW-1:0] dst_reg;
  logic [`NLB_MMIO_DW-1:0] rd_data;
  logic cfg_wr_en;

  assign wdata_u = mmio_wdata;

  // Setup registers are frozen while the test runs
  assign cfg_wr_en = mmio_wr_valid & ~(ctl.test_rst_n & ctl.start);

  // Engines take line addresses from the low bits
  assign src_addr = src_reg[`NLB_ADDR_W-1:0];
  assign dst_addr = dst_reg[`NLB_ADDR_W-1:0];

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge Clk_400)
  begin
    if (!rst_n)
    begin
      src_reg   <= '0;
      dst_reg   <= '0;
      num_lines <= '0;
      ctl       <= '0;
      cfg       <= '0;
    end
    else
    begin
      // CTL is never locked, so a running test can be stopped
      if (mmio_wr_valid && mmio_addr == `NLB_CSR_CTL)
        ctl <= wdata_u.ctl;
      if (cfg_wr_en)
      begin
        case (mmio_addr)
          `NLB_CSR_SRC_ADDR:  src_reg   <= wdata_u.raw;
          `NLB_CSR_DST_ADDR:  dst_reg   <= wdata_u.raw;
          `NLB_CSR_NUM_LINES: num_lines <= wdata_u.raw[`NLB_CNT_W-1:0];
          `NLB_CSR_CFG:       cfg       <= wdata_u.cfg;
          default:            ;
        endcase
      end
    end
  end

  // Scratchpad holds whatever software left there
  always_ff @(posedge Clk_400)
  begin
    if (cfg_wr_en && mmio_addr == `NLB_CSR_SCRATCH)
      scratch <= wdata_u.raw;
  end

  // ----------------------------------------
  // Readback mux
  // ----------------------------------------
  always_comb
  begin
    case (mmio_addr)
      `NLB_CSR_DFH:       rd_data = `NLB_DFH_VALUE;
      `NLB_CSR_SCRATCH:   rd_data = scratch;
      `NLB_CSR_SRC_ADDR:  rd_data = src_reg;
      `NLB_CSR_DST_ADDR:  rd_data = dst_reg;
      `NLB_CSR_NUM_LINES: rd_data = {{(`NLB_MMIO_DW-`NLB_CNT_W){1'b0}}, num_lines};
      `NLB_CSR_CTL:       rd_data = ctl;
      `NLB_CSR_CFG:       rd_data = cfg;
      // Bit 0 is the completion flag
      `NLB_CSR_STATUS:    rd_data = {{(`NLB_MMIO_DW-1){1'b0}}, test_done};
      // Writes in the upper half, reads in the lower
      `NLB_CSR_COUNTS:    rd_data = {num_writes, num_reads};
      `NLB_CSR_CLOCKS:    rd_data = num_clocks;
      default:            rd_data = '0;
    endcase
  end

  // Response one cycle after the read strobe
  always_ff @(posedge Clk_400)
  begin
    if (!rst_n)
      mmio_rsp_valid <= 1'b0;
    else
      mmio_rsp_valid <= mmio_rd_valid;
  end

  always_ff @(posedge Clk_400)
  begin
    mmio_rsp_tid  <= mmio_tid;
    mmio_rsp_data <= rd_data;
  end

  // Host sees no response it did not ask for
  a_rsp_after_rd: assert property (@(posedge Clk_400) disable iff (!rst_n)
    mmio_rsp_valid |-> $past(mmio_rd_valid));

endmodule

// ==== nlb_lpbk.f ====
+incdir+.
nlb_pkg.sv
nlb_csr.sv
nlb_test_ctl.sv
nlb_rd_engine.sv
nlb_wr_engine.sv
nlb_lpbk.sv
tb_nlb_lpbk.sv

// ==== nlb_lpbk.sv ====
/*
 * Native loopback top: register block, test control, read and write engines
 */
`timescale 1ns/1ps
`include "nlb_lpbk_settings.svh"

module nlb_lpbk
(
  input  logic                    Clk_400,
  input  logic                    rst_n,
  // MMIO from host
  input  logic                    mmio_wr_valid,
  input  logic                    mmio_rd_valid,
  input  logic [`NLB_MMIO_AW-1:0] mmio_addr,
  input  logic [`NLB_TID_W-1:0]   mmio_tid,
  input  logic [`NLB_MMIO_DW-1:0] mmio_wdata,
  output logic                    mmio_rsp_valid,
  output logic [`NLB_TID_W-1:0]   mmio_rsp_tid,
  output logic [`NLB_MMIO_DW-1:0] mmio_rsp_data,
  // Read channel
  output logic                    rd_req_valid,
  output logic [`NLB_ADDR_W-1:0]  rd_req_addr,
  output logic [`NLB_TID_W-1:0]   rd_req_tid,
  input  logic                    rd_almfull,
  input  logic                    rd_rsp_valid,
  input  logic [`NLB_TID_W-1:0]   rd_rsp_tid,
  input  logic [`NLB_DATA_W-1:0]  rd_rsp_data,
  // Write channel
  output logic                    wr_req_valid,
  output logic [`NLB_ADDR_W-1:0]  wr_req_addr,
  output logic [`NLB_TID_W-1:0]   wr_req_tid,
  output logic [`NLB_DATA_W-1:0]  wr_req_data,
  input  logic                    wr_almfull,
  input  logic                    wr_rsp_valid,
  input  logic [`NLB_TID_W-1:0]   wr_rsp_tid
);
  import nlb_pkg::*;

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------
  nlb_ctl_t ctl;
  nlb_cfg_t cfg;
  logic [`NLB_ADDR_W-1:0] src_addr;
  logic [`NLB_ADDR_W-1:0] dst_addr;
  logic [`NLB_CNT_W-1:0] num_lines;
  logic [`NLB_CNT_W-1:0] num_reads;
  logic [`NLB_CNT_W-1:0] num_writes;
  logic [63:0] num_clocks;
  logic start;
  logic rd_run;
  logic wr_copy;
  logic wr_pattern;
  logic test_done;
  // Read data on its way to the copy path
  logic rd_done_valid;
  logic [`NLB_TID_W-1:0] rd_done_tid;
  logic [`NLB_DATA_W-1:0] rd_done_data;

  nlb_csr nlb_csr_i
  (
    .Clk_400, .rst_n,
    .mmio_wr_valid, .mmio_rd_valid, .mmio_addr, .mmio_tid, .mmio_wdata,
    .test_done, .num_reads, .num_writes, .num_clocks,
    .mmio_rsp_valid, .mmio_rsp_tid, .mmio_rsp_data,
    .ctl, .cfg, .src_addr, .dst_addr, .num_lines
  );

  nlb_test_ctl nlb_test_ctl_i
  (
    .Clk_400, .rst_n, .ctl, .cfg, .num_lines,
    .rd_rsp_count (num_reads),
    .wr_rsp_count (num_writes),
    .start, .rd_run, .wr_copy, .wr_pattern, .test_done, .num_clocks
  );

  nlb_rd_engine nlb_rd_engine_i
  (
    .Clk_400, .rst_n, .start, .rd_run, .wr_copy, .test_done,
    .src_addr, .num_lines, .rd_almfull, .wr_almfull,
    .rd_rsp_valid, .rd_rsp_tid, .rd_rsp_data,
    .rd_req_valid, .rd_req_addr, .rd_req_tid,
    .rd_done_valid, .rd_done_tid, .rd_done_data, .num_reads
  );

  nlb_wr_engine nlb_wr_engine_i
  (
    .Clk_400, .rst_n, .start, .wr_copy, .wr_pattern, .test_done,
    .dst_addr, .num_lines, .wr_almfull,
    .rd_done_valid, .rd_done_tid, .rd_done_data,
    .wr_rsp_valid, .wr_rsp_tid,
    .wr_req_valid, .wr_req_addr, .wr_req_tid, .wr_req_data, .num_writes
  );

endmodule

// ==== nlb_lpbk_settings.svh ====
/*
 * Widths, MMIO register offsets and the outstanding-read limit
 */
`ifndef NLB_LPBK_SETTINGS_SVH
`define NLB_LPBK_SETTINGS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
// Cache-line address, in lines
`define NLB_ADDR_W 42
`define NLB_DATA_W 512
`define NLB_TID_W 16
`define NLB_MMIO_AW 16
`define NLB_MMIO_DW 64
// Line index and response counters
`define NLB_CNT_W 32
// Holds 0..NLB_PEND_THRESH
`define NLB_PEND_W 4

// Reads in flight before the engine holds off
`define NLB_PEND_THRESH 7

// ----------------------------------------
// Register byte offsets
// ----------------------------------------
`define NLB_CSR_DFH 16'h0000
`define NLB_CSR_SCRATCH 16'h0100
`define NLB_CSR_SRC_ADDR 16'h0120
`define NLB_CSR_DST_ADDR 16'h0128
`define NLB_CSR_NUM_LINES 16'h0130
`define NLB_CSR_CTL 16'h0138
`define NLB_CSR_CFG 16'h0140
`define NLB_CSR_STATUS 16'h0160
`define NLB_CSR_COUNTS 16'h0168
`define NLB_CSR_CLOCKS 16'h0170

// AFU type, end of list, revision 1
`define NLB_DFH_VALUE 64'h1000_0100_0000_0001

`endif

// ==== nlb_pkg.sv ====
/*
 * Test mode encoding, control and config register views, MMIO word union
 */
`include "nlb_lpbk_settings.svh"

package nlb_pkg;

  // ----------------------------------------
  // Test modes, CFG bits 4:2
  // ----------------------------------------
  // Unlisted codes run as READ
  typedef enum logic [2:0]
  {
    LPBK1 = 3'd0,
    READ  = 3'd1,
    WRITE = 3'd2,
    TRPUT = 3'd3
  } nlb_mode_e;

  // CTL register view
  typedef struct packed
  {
    logic [`NLB_MMIO_DW-4:0] rsvd;
    // Ends the test as if all lines were done
    logic force_cmp;
    logic start;
    // Low holds the test logic in reset
    logic test_rst_n;
  } nlb_ctl_t;

  // CFG register view
  typedef struct packed
  {
    logic [`NLB_MMIO_DW-6:0] rsvd_hi;
    nlb_mode_e mode;
    logic [1:0] rsvd_lo;
  } nlb_cfg_t;

  // One MMIO write word, read as CTL or as CFG by offset
  typedef union packed
  {
    logic [`NLB_MMIO_DW-1:0] raw;
    nlb_ctl_t ctl;
    nlb_cfg_t cfg;
  } nlb_csr_word_u;

endpackage

// ==== nlb_rd_engine.sv ====
/*
 * Read engine: source-line reads under the outstanding limit, response forwarding
 */
`timescale 1ns/1ps
`include "nlb_lpbk_settings.svh"

module nlb_rd_engine
(
  input  logic                   Clk_400,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   rd_run,
  input  logic                   wr_copy,
  input  logic                   test_done,
  input  logic [`NLB_ADDR_W-1:0] src_addr,
  input  logic [`NLB_CNT_W-1:0]  num_lines,
  input  logic                   rd_almfull,
  input  logic                   wr_almfull,
  input  logic                   rd_rsp_valid,
  input  logic [`NLB_TID_W-1:0]  rd_rsp_tid,
  input  logic [`NLB_DATA_W-1:0] rd_rsp_data,
  output logic                   rd_req_valid,
  output logic [`NLB_ADDR_W-1:0] rd_req_addr,
  output logic [`NLB_TID_W-1:0]  rd_req_tid,
  output logic                   rd_done_valid,
  output logic [`NLB_TID_W-1:0]  rd_done_tid,
  output logic [`NLB_DATA_W-1:0] rd_done_data,
  output logic [`NLB_CNT_W-1:0]  num_reads
);

  logic active;
  logic [`NLB_CNT_W-1:0] line_idx;
  logic [`NLB_PEND_W-1:0] pend;

  // Copy mode also waits on the write side, data goes straight there
  assign rd_req_valid = active & rd_run & ~test_done & (line_idx < num_lines)
                      & (pend < `NLB_PEND_THRESH) & ~rd_almfull
                      & ~(wr_copy & wr_almfull);
  assign rd_req_addr  = src_addr + `NLB_ADDR_W'(line_idx);
  assign rd_req_tid   = line_idx[`NLB_TID_W-1:0];

  always_ff @(posedge Clk_400)
  begin
    if (!rst_n)
    begin
      active    <= 1'b0;
      line_idx  <= '0;
      pend      <= '0;
      num_reads <= '0;
    end
    else if (!rd_run)
    begin
      active    <= 1'b0;
      num_reads <= '0;
    end
    else if (start)
    begin
      active    <= 1'b1;
      line_idx  <= '0;
      pend      <= '0;
      num_reads <= '0;
    end
    else
    begin
      if (rd_req_valid)
        line_idx <= line_idx + 1'b1;
      // One in, one out
      pend <= pend + `NLB_PEND_W'(rd_req_valid) - `NLB_PEND_W'(rd_rsp_valid);
      // Counts freeze at done
      if (rd_rsp_valid && !test_done)
        num_reads <= num_reads + 1'b1;
    end
  end

  // ----------------------------------------
  // Response forwarding to the write engine
  // ----------------------------------------
  always_ff @(posedge Clk_400)
  begin
    if (!rst_n)
      rd_done_valid <= 1'b0;
    else
      rd_done_valid <= rd_rsp_valid & rd_run;
  end

  always_ff @(posedge Clk_400)
  begin
    rd_done_tid  <= rd_rsp_tid;
    rd_done_data <= rd_rsp_data;
  end

  a_pend_limit: assert property (@(posedge Clk_400) disable iff (!rst_n)
    pend <= `NLB_PEND_THRESH);
  a_no_rd_almfull: assert property (@(posedge Clk_400) disable iff (!rst_n)
    rd_req_valid |-> !rd_almfull);

endmodule

// ==== nlb_test_ctl.sv ====
/*
 * Test control: start edge, mode decode, completion and clock counter
 */
`timescale 1ns/1ps
`include "nlb_lpbk_settings.svh"

module nlb_test_ctl
(
  input  logic                  Clk_400,
  input  logic                  rst_n,
  input  nlb_pkg::nlb_ctl_t     ctl,
  input  nlb_pkg::nlb_cfg_t     cfg,
  input  logic [`NLB_CNT_W-1:0] num_lines,
  input  logic [`NLB_CNT_W-1:0] rd_rsp_count,
  input  logic [`NLB_CNT_W-1:0] wr_rsp_count,
  output logic                  start,
  output logic                  rd_run,
  output logic                  wr_copy,
  output logic                  wr_pattern,
  output logic                  test_done,
  output logic [63:0]           num_clocks
);
  import nlb_pkg::*;

  logic run;
  logic run_q;
  logic done_q;
  logic all_done;

  // Test runs while out of test reset and started
  assign run   = ctl.test_rst_n & ctl.start;
  assign start = run & ~run_q;

  // Force only counts once the run is under way
  assign test_done = done_q | (run & run_q & ctl.force_cmp);

  // ----------------------------------------
  // Mode decode
  // ----------------------------------------
  always_comb
  begin
    rd_run     = 1'b0;
    wr_copy    = 1'b0;
    wr_pattern = 1'b0;
    all_done   = (rd_rsp_count == num_lines);
    case (cfg.mode)
      LPBK1:
      begin
        rd_run   = run;
        wr_copy  = run;
        all_done = (wr_rsp_count == num_lines);
      end
      WRITE:
      begin
        wr_pattern = run;
        all_done   = (wr_rsp_count == num_lines);
      end
      // Both streams must drain
      TRPUT:
      begin
        rd_run     = run;
        wr_pattern = run;
        all_done   = (wr_rsp_count == num_lines) && (rd_rsp_count == num_lines);
      end
      // READ and the unused codes
      default: rd_run = run;
    endcase
  end

  // Done and clocks hold only while the test is enabled
  always_ff @(posedge Clk_400)
  begin
    if (!rst_n)
    begin
      run_q      <= 1'b0;
      done_q     <= 1'b0;
      num_clocks <= '0;
    end
    else
    begin
      run_q <= run;
      if (!run)
      begin
        done_q     <= 1'b0;
        num_clocks <= '0;
      end
      else
      begin
        if (all_done)
          done_q <= 1'b1;
        // Counts from the start pulse up to done
        if (!test_done)
          num_clocks <= num_clocks + 64'd1;
      end
    end
  end

  // A new run always begins from a cleared done flag
  a_start_not_done: assert property (@(posedge Clk_400) disable iff (!rst_n)
    start |-> !test_done);

endmodule

// ==== nlb_wr_engine.sv ====
/*
 * Write engine: copy writes from read responses or pattern writes,
 * write-response counting
 */
`timescale 1ns/1ps
`include "nlb_lpbk_settings.svh"

module nlb_wr_engine
(
  input  logic                   Clk_400,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   wr_copy,
  input  logic                   wr_pattern,
  input  logic                   test_done,
  input  logic [`NLB_ADDR_W-1:0] dst_addr,
  input  logic [`NLB_CNT_W-1:0]  num_lines,
  input  logic                   wr_almfull,
  input  logic                   rd_done_valid,
  input  logic [`NLB_TID_W-1:0]  rd_done_tid,
  input  logic [`NLB_DATA_W-1:0] rd_done_data,
  input  logic                   wr_rsp_valid,
  input  logic [`NLB_TID_W-1:0]  wr_rsp_tid,
  output logic                   wr_req_valid,
  output logic [`NLB_ADDR_W-1:0] wr_req_addr,
  output logic [`NLB_TID_W-1:0]  wr_req_tid,
  output logic [`NLB_DATA_W-1:0] wr_req_data,
  output logic [`NLB_CNT_W-1:0]  num_writes
);

  logic wr_run;
  logic pat_active;
  logic [`NLB_CNT_W-1:0] pat_idx;
  logic copy_issue;
  logic pat_issue;

  assign wr_run = wr_copy | wr_pattern;

  // Copy writes go out as soon as the read data lands
  assign copy_issue = wr_copy & rd_done_valid & ~test_done;

  // Pattern writes back off on almost-full
  assign pat_issue = wr_pattern & pat_active & ~test_done
                   & (pat_idx < num_lines) & ~wr_almfull;

  // ----------------------------------------
  // Request mux
  // ----------------------------------------
  always_comb
  begin
    if (wr_copy)
    begin
      wr_req_valid = copy_issue;
      wr_req_addr  = dst_addr + `NLB_ADDR_W'(rd_done_tid);
      wr_req_tid   = rd_done_tid;
      wr_req_data  = rd_done_data;
    end
    else
    begin
      wr_req_valid = pat_issue;
      wr_req_addr  = dst_addr + `NLB_ADDR_W'(pat_idx);
      wr_req_tid   = pat_idx[`NLB_TID_W-1:0];
      // Line index repeated in every dword
      wr_req_data  = {(`NLB_DATA_W/32){pat_idx}};
    end
  end

  // ----------------------------------------
  // Pattern index and response count
  // ----------------------------------------
  always_ff @(posedge Clk_400)
  begin
    if (!rst_n)
    begin
      pat_active <= 1'b0;
      pat_idx    <= '0;
      num_writes <= '0;
    end
    else if (!wr_run)
    begin
      pat_active <= 1'b0;
      num_writes <= '0;
    end
    else if (start)
    begin
      // Pattern generation arms one cycle after start
      pat_active <= wr_pattern;
      pat_idx    <= '0;
      num_writes <= '0;
    end
    else
    begin
      if (pat_issue)
        pat_idx <= pat_idx + 1'b1;
      if (wr_rsp_valid && !test_done)
        num_writes <= num_writes + 1'b1;
    end
  end

  a_no_pat_almfull: assert property (@(posedge Clk_400) disable iff (!rst_n)
    (wr_pattern && wr_req_valid) |-> !wr_almfull);

  // Host only acknowledges lines that belong to the test
  a_rsp_tid_range: assert property (@(posedge Clk_400) disable iff (!rst_n)
    (wr_run && wr_rsp_valid) |-> (`NLB_CNT_W'(wr_rsp_tid) < num_lines));

endmodule

// ==== tb_nlb_lpbk.sv ====
/*
 * Directed testbench for the loopback accelerator with a host memory model,
 * MMIO access tasks, compare tasks and one task per test
 */
`timescale 1ns/1ps
`include "nlb_lpbk_settings.svh"

module tb_nlb_lpbk;
  import nlb_pkg::*;

  // Sum of all test lengths with generous margin
  localparam int MAX_CYCLES = 20000;

  logic                    Clk_400;
  logic                    rst_n;
  logic                    mmio_wr_valid;
  logic                    mmio_rd_valid;
  logic [`NLB_MMIO_AW-1:0] mmio_addr;
  logic [`NLB_TID_W-1:0]   mmio_tid;
  logic [`NLB_MMIO_DW-1:0] mmio_wdata;
  logic                    mmio_rsp_valid;
  logic [`NLB_TID_W-1:0]   mmio_rsp_tid;
  logic [`NLB_MMIO_DW-1:0] mmio_rsp_data;
  logic                    rd_req_valid;
  logic [`NLB_ADDR_W-1:0]  rd_req_addr;
  logic [`NLB_TID_W-1:0]   rd_req_tid;
  logic                    rd_almfull;
  logic                    rd_rsp_valid;
  logic [`NLB_TID_W-1:0]   rd_rsp_tid;
  logic [`NLB_DATA_W-1:0]  rd_rsp_data;
  logic                    wr_req_valid;
  logic [`NLB_ADDR_W-1:0]  wr_req_addr;
  logic [`NLB_TID_W-1:0]   wr_req_tid;
  logic [`NLB_DATA_W-1:0]  wr_req_data;
  logic                    wr_almfull;
  logic                    wr_rsp_valid;
  logic [`NLB_TID_W-1:0]   wr_rsp_tid;

  // ----------------------------------------
  // Host model state
  // ----------------------------------------
  // Sparse line memory keyed by line address
  logic [`NLB_DATA_W-1:0] mem [logic [`NLB_ADDR_W-1:0]];
  // Outstanding reads and writes with cycles left
  logic [`NLB_ADDR_W-1:0] rq_addr [$];
  logic [`NLB_TID_W-1:0] rq_tid [$];
  int rq_wait [$];
  logic [`NLB_TID_W-1:0] wq_tid [$];
  int wq_wait [$];
  integer seed;
  int cycles;
  int checks;
  int errors;
  int wr_seen;
  int rd_pick;
  int wr_pick;
  logic toggle_af;
  logic [`NLB_TID_W-1:0] next_tid;
  // Buffer bases of the running test
  logic [`NLB_ADDR_W-1:0] src_base;
  logic [`NLB_ADDR_W-1:0] dst_base;

  nlb_lpbk nlb_lpbk_i (.*);

  initial
  begin
    Clk_400 = 1'b0;
    forever #10 Clk_400 = ~Clk_400;
  end

  // Run limit
  always @(posedge Clk_400)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // Requests are captured mid-cycle and answered 1 ns after the edge
  always @(negedge Clk_400)
  begin
    if (rst_n && rd_req_valid)
    begin
      // ID is the line offset from the buffer base
      compare_word($sformatf("read ID at line %h", rd_req_addr), 64'(rd_req_tid),
                   64'(rd_req_addr - src_base));
      rq_addr.push_back(rd_req_addr);
      rq_tid.push_back(rd_req_tid);
      rq_wait.push_back(1 + ($random(seed) & 7));
    end
    if (rst_n && wr_req_valid)
    begin
      compare_word($sformatf("write ID at line %h", wr_req_addr), 64'(wr_req_tid),
                   64'(wr_req_addr - dst_base));
      mem[wr_req_addr] = wr_req_data;
      wr_seen = wr_seen + 1;
      wq_tid.push_back(wr_req_tid);
      wq_wait.push_back(1 + ($random(seed) & 7));
    end
    @(posedge Clk_400);
    #1;
    rd_rsp_valid = 1'b0;
    wr_rsp_valid = 1'b0;
    rd_pick = -1;
    wr_pick = -1;
    // First expired entry answers and order follows the random delays
    for (int i = 0; i < rq_wait.size(); i++)
    begin
      rq_wait[i] = rq_wait[i] - 1;
      if (rd_pick < 0 && rq_wait[i] <= 0)
        rd_pick = i;
    end
    for (int i = 0; i < wq_wait.size(); i++)
    begin
      wq_wait[i] = wq_wait[i] - 1;
      if (wr_pick < 0 && wq_wait[i] <= 0)
        wr_pick = i;
    end
    if (rd_pick >= 0)
    begin
      rd_rsp_valid = 1'b1;
      rd_rsp_tid   = rq_tid[rd_pick];
      rd_rsp_data  = mem.exists(rq_addr[rd_pick]) ? mem[rq_addr[rd_pick]] : '0;
      rq_addr.delete(rd_pick);
      rq_tid.delete(rd_pick);
      rq_wait.delete(rd_pick);
    end
    if (wr_pick >= 0)
    begin
      wr_rsp_valid = 1'b1;
      wr_rsp_tid   = wq_tid[wr_pick];
      wq_tid.delete(wr_pick);
      wq_wait.delete(wr_pick);
    end
    // Write side never fills up so wr_almfull always leaves the slack
    rd_almfull = toggle_af && (($random(seed) & 3) == 0);
    wr_almfull = toggle_af && (($random(seed) & 3) == 0);
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic compare_word(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_line(input string what, input logic [`NLB_DATA_W-1:0] got,
                              input logic [`NLB_DATA_W-1:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("FAIL %0t: %s holds %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_ctl(input string what, input nlb_ctl_t got, input nlb_ctl_t exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("FAIL %0t: %s rst_n=%b start=%b force=%b rsvd=%h, expected %h",
               $time, what, got.test_rst_n, got.start, got.force_cmp, got.rsvd, exp);
    end
  endtask

  // ----------------------------------------
  // MMIO access
  // ----------------------------------------
  task automatic mmio_write(input logic [`NLB_MMIO_AW-1:0] addr, input logic [63:0] data);
    @(posedge Clk_400);
    #1;
    mmio_wr_valid = 1'b1;
    mmio_addr     = addr;
    mmio_tid      = next_tid;
    mmio_wdata    = data;
    next_tid      = next_tid + 1'b1;
    @(posedge Clk_400);
    #1;
    mmio_wr_valid = 1'b0;
  endtask

  // Response must follow in the very next cycle with the same ID
  task automatic mmio_read(input logic [`NLB_MMIO_AW-1:0] addr, output logic [63:0] data);
    logic [`NLB_TID_W-1:0] tid;
    tid = next_tid;
    next_tid = next_tid + 1'b1;
    @(posedge Clk_400);
    #1;
    mmio_rd_valid = 1'b1;
    mmio_addr     = addr;
    mmio_tid      = tid;
    @(posedge Clk_400);
    #1;
    checks = checks + 1;
    data = mmio_rsp_data;
    if (!mmio_rsp_valid)
    begin
      errors = errors + 1;
      $display("At %0t the MMIO read of offset %h got no response in the next cycle",
               $time, addr);
    end
    else if (mmio_rsp_tid !== tid)
    begin
      errors = errors + 1;
      $display("FAIL %0t: MMIO response ID %h, expected %h", $time, mmio_rsp_tid, tid);
    end
    mmio_rd_valid = 1'b0;
  endtask

  // ----------------------------------------
  // Test helpers
  // ----------------------------------------
  // Low bits carry the full line address and the rest is random
  task automatic fill_source(input logic [`NLB_ADDR_W-1:0] src, input int lines);
    logic [`NLB_DATA_W-1:0] line;
    logic [`NLB_ADDR_W-1:0] a;
    for (int i = 0; i < lines; i++)
    begin
      a = src + `NLB_ADDR_W'(i);
      for (int w = 0; w < `NLB_DATA_W / 32; w++)
        line[w*32 +: 32] = $random(seed);
      line[`NLB_ADDR_W-1:0] = a;
      mem[a] = line;
    end
  endtask

  task automatic start_test(input nlb_mode_e mode, input logic [`NLB_ADDR_W-1:0] src,
                            input logic [`NLB_ADDR_W-1:0] dst, input int lines);
    nlb_cfg_t cfg_w;
    cfg_w = '0;
    cfg_w.mode = mode;
    src_base = src;
    dst_base = dst;
    // Test reset first lifts the write lock
    mmio_write(`NLB_CSR_CTL, 64'h0);
    mmio_write(`NLB_CSR_SRC_ADDR, 64'(src));
    mmio_write(`NLB_CSR_DST_ADDR, 64'(dst));
    mmio_write(`NLB_CSR_NUM_LINES, 64'(lines));
    mmio_write(`NLB_CSR_CFG, cfg_w);
    mmio_write(`NLB_CSR_CTL, 64'h3);
  endtask

  task automatic wait_done();
    logic [63:0] status;
    status = '0;
    while (status[0] !== 1'b1)
      mmio_read(`NLB_CSR_STATUS, status);
  endtask

  // Let every outstanding host response reach the DUT
  task automatic drain_host();
    while (rq_wait.size() != 0 || wq_wait.size() != 0)
      @(posedge Clk_400);
    repeat (2) @(posedge Clk_400);
    #1;
  endtask

  task automatic check_copy(input logic [`NLB_ADDR_W-1:0] src,
                            input logic [`NLB_ADDR_W-1:0] dst, input int lines);
    logic [`NLB_ADDR_W-1:0] d;
    for (int i = 0; i < lines; i++)
    begin
      d = dst + `NLB_ADDR_W'(i);
      if (!mem.exists(d))
      begin
        checks = checks + 1;
        errors = errors + 1;
        $display("At %0t destination line %0d was never written", $time, i);
      end
      else
        compare_line($sformatf("copy line %0d", i), mem[d], mem[src + `NLB_ADDR_W'(i)]);
    end
  endtask

  // Line i holds i in every 32-bit word
  task automatic check_pattern(input logic [`NLB_ADDR_W-1:0] dst, input int lines);
    logic [`NLB_ADDR_W-1:0] d;
    logic [31:0] iv;
    for (int i = 0; i < lines; i++)
    begin
      d = dst + `NLB_ADDR_W'(i);
      iv = 32'(i);
      if (!mem.exists(d))
      begin
        checks = checks + 1;
        errors = errors + 1;
        $display("At %0t pattern line %0d was never written", $time, i);
      end
      else
        compare_line($sformatf("pattern line %0d", i), mem[d], {(`NLB_DATA_W/32){iv}});
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, errors - errs_before);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_registers();
    logic [63:0] d;
    int e;
    e = errors;
    mmio_read(`NLB_CSR_DFH, d);
    compare_word("DFH", d, `NLB_DFH_VALUE);
    mmio_write(`NLB_CSR_SCRATCH, 64'h0123_4567_89ab_cdef);
    mmio_read(`NLB_CSR_SCRATCH, d);
    compare_word("SCRATCH", d, 64'h0123_4567_89ab_cdef);
    mmio_read(16'h0200, d);
    compare_word("unmapped offset", d, 64'h0);
    report_test("registers", e);
  endtask

  task automatic test_lpbk1();
    logic [63:0] d;
    int e;
    e = errors;
    fill_source(42'h1000, 32);
    toggle_af = 1'b1;
    start_test(LPBK1, 42'h1000, 42'h2000, 32);
    wait_done();
    toggle_af = 1'b0;
    drain_host();
    check_copy(42'h1000, 42'h2000, 32);
    mmio_read(`NLB_CSR_COUNTS, d);
    compare_word("LPBK1 COUNTS", d, {32'd32, 32'd32});
    mmio_read(`NLB_CSR_STATUS, d);
    compare_word("LPBK1 STATUS", d, 64'h1);
    mmio_read(`NLB_CSR_CLOCKS, d);
    checks = checks + 1;
    if (d == 64'h0)
    begin
      errors = errors + 1;
      $display("FAIL %0t: CLOCKS read zero after a finished test", $time);
    end
    report_test("lpbk1", e);
  endtask

  task automatic test_read();
    logic [63:0] d;
    int e;
    int w0;
    e = errors;
    w0 = wr_seen;
    start_test(READ, 42'h3000, 42'h3800, 20);
    wait_done();
    drain_host();
    checks = checks + 1;
    if (wr_seen != w0)
    begin
      errors = errors + 1;
      $display("At %0t the READ test issued %0d write requests", $time, wr_seen - w0);
    end
    mmio_read(`NLB_CSR_COUNTS, d);
    compare_word("READ COUNTS", d, {32'd0, 32'd20});
    mmio_read(`NLB_CSR_STATUS, d);
    compare_word("READ STATUS", d, 64'h1);
    report_test("read", e);
  endtask

  task automatic test_write_trput();
    logic [63:0] d;
    int e;
    e = errors;
    toggle_af = 1'b1;
    start_test(WRITE, 42'h0, 42'h4000, 16);
    wait_done();
    toggle_af = 1'b0;
    drain_host();
    check_pattern(42'h4000, 16);
    mmio_read(`NLB_CSR_COUNTS, d);
    compare_word("WRITE COUNTS", d, {32'd16, 32'd0});
    // Independent read stream alongside the pattern writes
    fill_source(42'h5000, 16);
    toggle_af = 1'b1;
    start_test(TRPUT, 42'h5000, 42'h6000, 16);
    wait_done();
    toggle_af = 1'b0;
    drain_host();
    check_pattern(42'h6000, 16);
    mmio_read(`NLB_CSR_COUNTS, d);
    compare_word("TRPUT COUNTS", d, {32'd16, 32'd16});
    report_test("write_trput", e);
  endtask

  task automatic test_write_lock();
    logic [63:0] d;
    nlb_ctl_t ctl_w;
    int e;
    e = errors;
    start_test(READ, 42'h7000, 42'h7800, 100);
    mmio_write(`NLB_CSR_SRC_ADDR, 64'h9999);
    mmio_read(`NLB_CSR_SRC_ADDR, d);
    compare_word("locked SRC_ADDR", d, 64'h7000);
    // Still running with one reserved bit set
    ctl_w = nlb_ctl_t'(64'h103);
    mmio_write(`NLB_CSR_CTL, ctl_w);
    mmio_read(`NLB_CSR_CTL, d);
    compare_ctl("CTL while running", nlb_ctl_t'(d), ctl_w);
    wait_done();
    drain_host();
    report_test("write_lock", e);
  endtask

  task automatic test_force_reset();
    logic [63:0] d;
    int e;
    e = errors;
    start_test(READ, 42'h8000, 42'h9000, 4000);
    repeat (50) @(posedge Clk_400);
    mmio_write(`NLB_CSR_CTL, 64'h7);
    mmio_read(`NLB_CSR_STATUS, d);
    compare_word("forced STATUS", d, 64'h1);
    drain_host();
    // An unforced run needs at least one cycle per line
    repeat (4000) @(posedge Clk_400);
    mmio_read(`NLB_CSR_COUNTS, d);
    checks = checks + 1;
    if (d[31:0] >= 32'd4000)
    begin
      errors = errors + 1;
      $display("FAIL %0t: forced read count %0d, expected below 4000", $time, d[31:0]);
    end
    // Test reset clears done and counts
    mmio_write(`NLB_CSR_CTL, 64'h0);
    mmio_read(`NLB_CSR_STATUS, d);
    compare_word("STATUS after test reset", d, 64'h0);
    mmio_read(`NLB_CSR_COUNTS, d);
    compare_word("COUNTS after test reset", d, 64'h0);
    report_test("force_reset", e);
  endtask

  initial
  begin
    seed = 32'he1d6;
    cycles = 0;
    checks = 0;
    errors = 0;
    wr_seen = 0;
    toggle_af = 1'b0;
    next_tid = '0;
    src_base = '0;
    dst_base = '0;
    rst_n = 1'b0;
    mmio_wr_valid = 1'b0;
    mmio_rd_valid = 1'b0;
    mmio_addr = '0;
    mmio_tid = '0;
    mmio_wdata = '0;
    rd_almfull = 1'b0;
    wr_almfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_tid = '0;
    rd_rsp_data = '0;
    wr_rsp_valid = 1'b0;
    wr_rsp_tid = '0;
    repeat (2) @(posedge Clk_400);
    #1;
    rst_n = 1'b1;
    test_registers();
    test_lpbk1();
    test_read();
    test_write_trput();
    test_write_lock();
    test_force_reset();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
